/* design/icache_pkg.sv */
// Instruction cache shared definitions
package icache_pkg;

	// ====================
	// Sizes and constants
	// ====================
	localparam int ADDR_W = 32;
	localparam int LINE_W = 128;
	localparam int BEAT_W = 64;
	localparam int WORD_W = 32;
	localparam int WORDS = LINE_W / WORD_W;
	localparam int INDEX_W = 4;
	localparam int NUM_LINES = 1 << INDEX_W;
	// Byte offset within a 16-byte line
	localparam int OFFS_W = 4;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFS_W;
	localparam int WAIT_CNT_W = 3;
	localparam int FILL_CNT_W = 32;

	localparam logic [ADDR_W-1:0] RESET_PC = 32'hFFFC0000;
	localparam logic [WAIT_CNT_W-1:0] ROM_READ_LAT = 3'd1;
	localparam logic [WAIT_CNT_W-1:0] L1_WRITE_LAT = 3'd3;
	// RISC-V style addi x0,x0,0
	localparam logic [WORD_W-1:0] NOP_WORD = 32'h00000013;
	localparam logic [WORD_W-1:0] ROM_SIGNATURE = 32'h5A3C_96E1;

	// Bus cycle type identifiers
	localparam logic [2:0] CTI_CLASSIC = 3'b000;
	localparam logic [2:0] CTI_INCR = 3'b001;
	localparam logic [2:0] CTI_END = 3'b111;

	// ====================
	// Types
	// ====================
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LINE_W-1:0] line_t;

	typedef enum logic [1:0] {
		FLT_NONE = 2'd0,
		FLT_BUS  = 2'd3
	} fault_e;

	// One write into the cache arrays
	typedef struct packed {
		logic [INDEX_W-1:0] index;
		logic [TAG_W-1:0]   tag;
		line_t              line;
		fault_e             flt;
	} fill_s;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic [2:0] cti;
		addr_t      adr;
	} bus_req_s;

	typedef struct packed {
		logic              ack;
		logic              err;
		logic [BEAT_W-1:0] dat;
	} bus_rsp_s;

	// Boot ROM region is the top 256 KB of the address space
	function automatic logic is_rom_addr(input addr_t adr);
		return &adr[ADDR_W-1:18];
	endfunction

endpackage

/* design/l1_icache.sv */
// Direct-mapped L1 instruction cache
`timescale 1ns/1ps

module l1_icache (
	input  logic                               clk,
	input  logic                               rst_i,
	input  icache_pkg::addr_t                  lookup_adr_i,
	output logic                               hit_o,
	output icache_pkg::line_t                  line_o,
	output icache_pkg::fault_e                 flt_o,
	input  logic                               fill_we_i,
	input  icache_pkg::fill_s                  fill_i,
	input  logic                               inv_we_i,
	input  logic [icache_pkg::INDEX_W-1:0]     inv_index_i
);

	// ====================
	// Storage
	// ====================
	icache_pkg::line_t                data_mem [icache_pkg::NUM_LINES];
	logic [icache_pkg::TAG_W-1:0]     tag_mem [icache_pkg::NUM_LINES];
	icache_pkg::fault_e               flt_mem [icache_pkg::NUM_LINES];
	logic [icache_pkg::NUM_LINES-1:0] valid;

	logic [icache_pkg::INDEX_W-1:0]   lk_index;
	logic [icache_pkg::TAG_W-1:0]     lk_tag;

	// Split the fetch address into index and tag
	assign lk_index = lookup_adr_i[icache_pkg::OFFS_W +: icache_pkg::INDEX_W];
	assign lk_tag = lookup_adr_i[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];

	// ====================
	// Lookup
	// ====================
	// Hit path is purely combinational
	assign hit_o = valid[lk_index] && (tag_mem[lk_index] == lk_tag);
	assign line_o = data_mem[lk_index];
	assign flt_o = flt_mem[lk_index];

	// Line contents, written only by the miss controller
	always_ff @(posedge clk) begin
		if (fill_we_i) begin
			data_mem[fill_i.index] <= fill_i.line;
			tag_mem[fill_i.index] <= fill_i.tag;
			flt_mem[fill_i.index] <= fill_i.flt;
		end
	end

	// Valid bits
	// Fill sets one entry, invalidate clears one
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid <= '0;
		end else begin
			if (fill_we_i) begin
				valid[fill_i.index] <= 1'b1;
			end
			if (inv_we_i) begin
				valid[inv_index_i] <= 1'b0;
			end
		end
	end

	// Controller sequences fill and invalidate in separate states
	// so the two write ports never collide
	assert property (@(posedge clk) disable iff (rst_i)
		!(fill_we_i && inv_we_i))
	else $error("l1_icache: fill and invalidate in the same cycle");

endmodule

/* design/boot_rom.sv */
// Boot ROM line source
`timescale 1ns/1ps

module boot_rom (
	input  logic              clk,
	input  icache_pkg::addr_t adr_i,
	output icache_pkg::line_t line_o
);

	icache_pkg::addr_t line_base;
	icache_pkg::line_t rom_line_d;
	// Read pipeline, models the synchronous ROM macro
	icache_pkg::line_t rom_pipe [icache_pkg::ROM_READ_LAT];

	assign line_base = {adr_i[icache_pkg::ADDR_W-1:icache_pkg::OFFS_W],
		{icache_pkg::OFFS_W{1'b0}}};

	// Each word is its own byte address XOR the signature
	always_comb begin
		for (int w = 0; w < icache_pkg::WORDS; w++) begin
			rom_line_d[w*icache_pkg::WORD_W +: icache_pkg::WORD_W] =
				(line_base + icache_pkg::addr_t'(w * (icache_pkg::WORD_W / 8)))
				^ icache_pkg::ROM_SIGNATURE;
		end
	end

	always_ff @(posedge clk) begin
		rom_pipe[0] <= rom_line_d;
		for (int i = 1; i < icache_pkg::ROM_READ_LAT; i++) begin
			rom_pipe[i] <= rom_pipe[i-1];
		end
	end

	assign line_o = rom_pipe[icache_pkg::ROM_READ_LAT-1];

endmodule

/* design/icache_miss_ctrl.sv */
// Instruction cache miss controller
`timescale 1ns/1ps

module icache_miss_ctrl (
	input  logic                                clk,
	input  logic                                rst_i,
	input  logic                                fetch_req_i,
	input  icache_pkg::addr_t                   fetch_adr_i,
	input  logic                                hit_i,
	output logic                                idle_o,
	input  logic                                inv_i,
	input  icache_pkg::addr_t                   inv_adr_i,
	output icache_pkg::addr_t                   rom_adr_o,
	input  icache_pkg::line_t                   rom_line_i,
	output logic                                fill_we_o,
	output icache_pkg::fill_s                   fill_o,
	output logic                                inv_we_o,
	output logic [icache_pkg::INDEX_W-1:0]      inv_index_o,
	output icache_pkg::bus_req_s                bus_req_o,
	input  icache_pkg::bus_rsp_s                bus_rsp_i,
	output logic [icache_pkg::FILL_CNT_W-1:0]   fill_count_o
);

	typedef enum logic [2:0] {
		IDLE,
		ROM_WAIT,
		BUS_BEAT,
		FILL,
		WRITE_WAIT
	} state_e;

	state_e                              state;
	// Line-aligned address of the miss being serviced
	icache_pkg::addr_t                   miss_adr;
	logic [icache_pkg::WAIT_CNT_W-1:0]   wait_cnt;
	// Low for the first beat and high for the second
	logic                                beat;
	icache_pkg::line_t                   fill_line;
	icache_pkg::fault_e                  fill_flt;
	logic                                inv_pend;
	icache_pkg::addr_t                   inv_adr_r;
	icache_pkg::bus_req_s                bus_req;
	logic [icache_pkg::FILL_CNT_W-1:0]   fill_count;

	// ====================
	// Main state machine
	// ====================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= IDLE;
			miss_adr <= icache_pkg::RESET_PC;
			wait_cnt <= '0;
			beat <= 1'b0;
			inv_pend <= 1'b0;
			bus_req.cyc <= 1'b0;
			bus_req.stb <= 1'b0;
			bus_req.cti <= icache_pkg::CTI_CLASSIC;
			fill_count <= '0;
		end else begin
			case (state)
			IDLE: begin
				// Pending invalidate wins over a miss and takes this cycle
				if (inv_pend) begin
					inv_pend <= 1'b0;
				end else if (fetch_req_i && !hit_i) begin
					miss_adr <= {fetch_adr_i[icache_pkg::ADDR_W-1:icache_pkg::OFFS_W],
						{icache_pkg::OFFS_W{1'b0}}};
					wait_cnt <= '0;
					beat <= 1'b0;
					if (icache_pkg::is_rom_addr(fetch_adr_i))
						state <= ROM_WAIT;
					else
						state <= BUS_BEAT;
				end
			end
			ROM_WAIT: begin
				// ROM data is ready once the read latency has passed
				wait_cnt <= wait_cnt + 1'b1;
				if (wait_cnt == icache_pkg::ROM_READ_LAT) begin
					fill_line <= rom_line_i;
					fill_flt <= icache_pkg::FLT_NONE;
					state <= FILL;
				end
			end
			BUS_BEAT: begin
				if (!bus_req.cyc) begin
					// Open the burst at the line base
					bus_req.cyc <= 1'b1;
					bus_req.stb <= 1'b1;
					bus_req.cti <= icache_pkg::CTI_INCR;
					bus_req.adr <= miss_adr;
				end else if (bus_rsp_i.err) begin
					// Abort and fill the line with NOPs
					bus_req.cyc <= 1'b0;
					bus_req.stb <= 1'b0;
					bus_req.cti <= icache_pkg::CTI_CLASSIC;
					fill_line <= {icache_pkg::WORDS{icache_pkg::NOP_WORD}};
					fill_flt <= icache_pkg::FLT_BUS;
					fill_count <= fill_count + 1'b1;
					state <= FILL;
				end else if (bus_rsp_i.ack) begin
					if (!beat) begin
						fill_line[icache_pkg::BEAT_W-1:0] <= bus_rsp_i.dat;
						beat <= 1'b1;
						bus_req.cti <= icache_pkg::CTI_END;
						bus_req.adr <= bus_req.adr +
							icache_pkg::addr_t'(icache_pkg::BEAT_W / 8);
					end else begin
						// Last beat closes the cycle
						fill_line[icache_pkg::LINE_W-1:icache_pkg::BEAT_W] <= bus_rsp_i.dat;
						fill_flt <= icache_pkg::FLT_NONE;
						bus_req.cyc <= 1'b0;
						bus_req.stb <= 1'b0;
						bus_req.cti <= icache_pkg::CTI_CLASSIC;
						fill_count <= fill_count + 1'b1;
						state <= FILL;
					end
				end
			end
			FILL: begin
				// Write strobe is high for exactly this cycle
				wait_cnt <= '0;
				state <= WRITE_WAIT;
			end
			WRITE_WAIT: begin
				// Let the L1 write settle before fetch resumes
				wait_cnt <= wait_cnt + 1'b1;
				if (wait_cnt == icache_pkg::L1_WRITE_LAT)
					state <= IDLE;
			end
			default: begin
				state <= IDLE;
			end
			endcase

			// Invalidate requests are latched in any state
			if (inv_i) begin
				inv_pend <= 1'b1;
				inv_adr_r <= inv_adr_i;
			end
		end
	end

	// ====================
	// Outputs
	// ====================
	assign idle_o = (state == IDLE) && !inv_pend;
	assign inv_we_o = (state == IDLE) && inv_pend;
	assign inv_index_o = inv_adr_r[icache_pkg::OFFS_W +: icache_pkg::INDEX_W];
	assign fill_we_o = (state == FILL);
	assign rom_adr_o = miss_adr;
	assign bus_req_o = bus_req;
	assign fill_count_o = fill_count;

	always_comb begin
		fill_o.index = miss_adr[icache_pkg::OFFS_W +: icache_pkg::INDEX_W];
		fill_o.tag = miss_adr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
		fill_o.line = fill_line;
		fill_o.flt = fill_flt;
	end

	// Strobe only inside an open cycle of the burst state
	assert property (@(posedge clk) disable iff (rst_i)
		bus_req.stb |-> bus_req.cyc && (state == BUS_BEAT))
	else $error("icache_miss_ctrl: stb without cyc");

	// Back-pressure holds the request until the slave answers
	assert property (@(posedge clk) disable iff (rst_i)
		bus_req.cyc && !bus_rsp_i.ack && !bus_rsp_i.err |=> bus_req.cyc)
	else $error("icache_miss_ctrl: cyc dropped before ack or err");

endmodule

/* design/icache_subsys.sv */
// Instruction fetch cache subsystem
`timescale 1ns/1ps

module icache_subsys (
	input  logic                                clk,
	input  logic                                rst_i,
	input  logic                                fetch_req_i,
	input  icache_pkg::addr_t                   fetch_adr_i,
	output logic                                fetch_valid_o,
	output icache_pkg::line_t                   fetch_line_o,
	output icache_pkg::fault_e                  fetch_flt_o,
	input  logic                                inv_i,
	input  icache_pkg::addr_t                   inv_adr_i,
	output icache_pkg::bus_req_s                bus_req_o,
	input  icache_pkg::bus_rsp_s                bus_rsp_i,
	output logic [icache_pkg::FILL_CNT_W-1:0]   fill_count_o
);

	logic                              hit;
	logic                              idle;
	icache_pkg::addr_t                 rom_adr;
	icache_pkg::line_t                 rom_line;
	logic                              fill_we;
	icache_pkg::fill_s                 fill;
	logic                              inv_we;
	logic [icache_pkg::INDEX_W-1:0]    inv_index;

	// Hit data is only handed out while no refill is in flight
	assign fetch_valid_o = fetch_req_i && hit && idle;

	// ====================
	// Cache arrays
	// ====================
	l1_icache u_l1 (
		.clk          (clk),
		.rst_i        (rst_i),
		.lookup_adr_i (fetch_adr_i),
		.hit_o        (hit),
		.line_o       (fetch_line_o),
		.flt_o        (fetch_flt_o),
		.fill_we_i    (fill_we),
		.fill_i       (fill),
		.inv_we_i     (inv_we),
		.inv_index_i  (inv_index)
	);

	boot_rom u_rom (
		.clk    (clk),
		.adr_i  (rom_adr),
		.line_o (rom_line)
	);

	// Refill and invalidate sequencing
	icache_miss_ctrl u_ctrl (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_req_i  (fetch_req_i),
		.fetch_adr_i  (fetch_adr_i),
		.hit_i        (hit),
		.idle_o       (idle),
		.inv_i        (inv_i),
		.inv_adr_i    (inv_adr_i),
		.rom_adr_o    (rom_adr),
		.rom_line_i   (rom_line),
		.fill_we_o    (fill_we),
		.fill_o       (fill),
		.inv_we_o     (inv_we),
		.inv_index_o  (inv_index),
		.bus_req_o    (bus_req_o),
		.bus_rsp_i    (bus_rsp_i),
		.fill_count_o (fill_count_o)
	);

endmodule

/* sim/tb_icache_subsys.sv */
// Instruction cache subsystem testbench
`timescale 1ns/1ps

module tb_icache_subsys;

	localparam int FETCH_TIMEOUT = 200;
	localparam int RANDOM_FETCHES = 40;
	// Lines in this window answer with err
	localparam logic [31:0] FAULT_LO = 32'h0000_8000;
	localparam logic [31:0] FAULT_HI = 32'h0000_807F;
	localparam logic [31:0] MEM_BASE = 32'h0000_1000;
	// ROM read, fill write and L1 write wait, counted from leaving idle
	localparam int ROM_MISS_CYCLES = (int'(icache_pkg::ROM_READ_LAT) + 1) + 1 +
		(int'(icache_pkg::L1_WRITE_LAT) + 1);

	logic clk = 1'b0;
	logic rst_i;
	logic fetch_req_i;
	icache_pkg::addr_t fetch_adr_i;
	logic fetch_valid_o;
	icache_pkg::line_t fetch_line_o;
	icache_pkg::fault_e fetch_flt_o;
	logic inv_i;
	icache_pkg::addr_t inv_adr_i;
	icache_pkg::bus_req_s bus_req_o;
	icache_pkg::bus_rsp_s bus_rsp_i = '0;
	logic [31:0] fill_count_o;

	// Slave and scoreboard state
	logic [15:0] lfsr_delay = 16'd15;
	logic [15:0] lfsr_addr = 16'd15;
	logic [31:0] delay_bits;
	int ack_wait;
	logic beat_open;
	int beat_idx;
	logic bus_cyc;
	int bus_starts = 0;
	int expected_fills = 0;
	logic model_valid [16];
	logic [31:0] model_tag [16];

	icache_subsys UUT (
		.clk           (clk),
		.rst_i         (rst_i),
		.fetch_req_i   (fetch_req_i),
		.fetch_adr_i   (fetch_adr_i),
		.fetch_valid_o (fetch_valid_o),
		.fetch_line_o  (fetch_line_o),
		.fetch_flt_o   (fetch_flt_o),
		.inv_i         (inv_i),
		.inv_adr_i     (inv_adr_i),
		.bus_req_o     (bus_req_o),
		.bus_rsp_i     (bus_rsp_i),
		.fill_count_o  (fill_count_o)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	// ====================
	// Helpers
	// ====================
	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(inout logic [15:0] state, input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], state[15]};
			state = lfsr_step(state);
		end
	endtask

	function automatic logic in_fault_window(input logic [31:0] adr);
		return (adr >= FAULT_LO) && (adr <= FAULT_HI);
	endfunction

	// Memory word is word address times 3 plus 1
	function automatic logic [31:0] mem_word(input logic [31:0] adr);
		return (adr >> 2) * 3 + 1;
	endfunction

	// Expected line for any address from the ROM rule, the fault window or memory
	function automatic icache_pkg::line_t expected_line(input icache_pkg::addr_t adr);
		icache_pkg::line_t l;
		logic [31:0] base;
		base = {adr[31:4], 4'h0};
		for (int w = 0; w < 4; w++) begin
			if (icache_pkg::is_rom_addr(adr))
				l[w*32 +: 32] = (base + 32'(4 * w)) ^ icache_pkg::ROM_SIGNATURE;
			else if (in_fault_window(base))
				l[w*32 +: 32] = icache_pkg::NOP_WORD;
			else
				l[w*32 +: 32] = mem_word(base + 32'(4 * w));
		end
		return l;
	endfunction

	function automatic icache_pkg::fault_e expected_flt(input icache_pkg::addr_t adr);
		if (!icache_pkg::is_rom_addr(adr) && in_fault_window({adr[31:4], 4'h0}))
			return icache_pkg::FLT_BUS;
		return icache_pkg::FLT_NONE;
	endfunction

	task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual,
				expected);
			$display("TESTS FAILED");
			$fatal(1, "Stopping after the first failed check");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "Stopping after a timeout");
	endtask

	// ====================
	// Bus slave model
	// ====================
	assign bus_cyc = bus_req_o.cyc;

	always @(posedge bus_cyc) begin
		bus_starts++;
	end

	always @(negedge clk) begin
		if (rst_i || !bus_req_o.cyc) begin
			bus_rsp_i = '0;
			beat_open = 1'b0;
			beat_idx = 0;
		end else if (bus_rsp_i.ack || bus_rsp_i.err) begin
			// Response lasts one cycle
			bus_rsp_i = '0;
			beat_open = 1'b0;
			beat_idx++;
		end else if (bus_req_o.stb) begin
			if (!beat_open) begin
				beat_open = 1'b1;
				draw_bits(lfsr_delay, 2, delay_bits);
				ack_wait = int'(delay_bits);
			end
			if (ack_wait > 0) begin
				ack_wait--;
			end else begin
				// First beat at line base with cti 001 and last at base+8 with 111
				check_equal(128'(bus_req_o.cti), (beat_idx == 0) ? 128'h1 : 128'h7, "burst cti");
				check_equal(128'(bus_req_o.adr[3:0]), (beat_idx == 0) ? 128'h0 : 128'h8,
					"beat address offset");
				if (in_fault_window(bus_req_o.adr)) begin
					bus_rsp_i.err = 1'b1;
				end else begin
					bus_rsp_i.ack = 1'b1;
					bus_rsp_i.dat = {mem_word(bus_req_o.adr + 32'd4), mem_word(bus_req_o.adr)};
				end
			end
		end
	end

	// ====================
	// Fetch and invalidate
	// ====================
	task automatic fetch_and_check(input icache_pkg::addr_t adr);
		logic [31:0] line_adr;
		logic [3:0] idx;
		logic cached;
		logic will_fill;
		int starts_before;
		int cycles;
		line_adr = {adr[31:4], 4'h0};
		idx = adr[7:4];
		cached = model_valid[idx] && (model_tag[idx] == line_adr);
		// Misses outside the ROM region cost one bus fill
		will_fill = !cached && !icache_pkg::is_rom_addr(adr);
		starts_before = bus_starts;
		@(negedge clk);
		fetch_req_i = 1'b1;
		fetch_adr_i = adr;
		cycles = 0;
		@(negedge clk);
		while (!fetch_valid_o) begin
			cycles++;
			if (cycles > FETCH_TIMEOUT)
				abort_run($sformatf("Timeout: fetch of %h never became valid", adr));
			@(negedge clk);
		end
		check_equal(fetch_line_o, expected_line(adr), "fetched line");
		check_equal(128'(fetch_flt_o), 128'(expected_flt(adr)), "fetch fault code");
		// Hits answer at once and ROM refills take a fixed time
		if (cached)
			check_equal(128'(cycles), 128'h0, "hit latency");
		else if (icache_pkg::is_rom_addr(adr))
			check_equal(128'(cycles), 128'(ROM_MISS_CYCLES), "ROM refill latency");
		fetch_req_i = 1'b0;
		model_valid[idx] = 1'b1;
		model_tag[idx] = line_adr;
		if (will_fill)
			expected_fills++;
		check_equal(128'(fill_count_o), 128'(expected_fills), "bus fill count");
		check_equal(128'(bus_starts), 128'(starts_before + int'(will_fill)), "bus cycles started");
	endtask

	task automatic invalidate_line(input icache_pkg::addr_t adr);
		@(negedge clk);
		inv_i = 1'b1;
		inv_adr_i = adr;
		@(negedge clk);
		inv_i = 1'b0;
		model_valid[adr[7:4]] = 1'b0;
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		logic [31:0] r;
		icache_pkg::addr_t adr;
		rst_i = 1'b1;
		fetch_req_i = 1'b0;
		fetch_adr_i = '0;
		inv_i = 1'b0;
		inv_adr_i = '0;
		for (int i = 0; i < 16; i++)
			model_valid[i] = 1'b0;
		repeat (16) @(negedge clk);
		rst_i = 1'b0;
		check_equal(128'(fill_count_o), 128'h0, "fill count after reset");
		check_equal(128'(bus_req_o.cyc), 128'h0, "cyc after reset");

		// Cold miss, then a hit on the same line
		fetch_and_check(32'h0000_1234);
		fetch_and_check(32'h0000_1238);
		// Boot ROM region and the bus fault window
		fetch_and_check(icache_pkg::RESET_PC + 32'h20);
		fetch_and_check(32'h0000_8010);
		// Invalidate forces a new fill
		invalidate_line(32'h0000_1230);
		fetch_and_check(32'h0000_1234);

		// Mixed random traffic
		for (int n = 0; n < RANDOM_FETCHES; n++) begin
			draw_bits(lfsr_addr, 9, r);
			case (r[8:7])
			2'd2: adr = icache_pkg::RESET_PC + (32'(r[2:0]) << 4) + (32'(r[6:5]) << 2);
			2'd3: adr = FAULT_LO + (32'(r[2:0]) << 4) + (32'(r[6:5]) << 2);
			default: adr = MEM_BASE + (32'(r[4:0]) << 4) + (32'(r[6:5]) << 2);
			endcase
			fetch_and_check(adr);
		end
		check_equal(128'(fill_count_o), 128'(expected_fills), "final bus fill count");
		$display("Bus fills counted: %0d", expected_fills);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* icache_subsys.f */
design/icache_pkg.sv
design/l1_icache.sv
design/boot_rom.sv
design/icache_miss_ctrl.sv
design/icache_subsys.sv
sim/tb_icache_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f icache_subsys.f \
	--top-module tb_icache_subsys -o sim_icache_subsys

out=$(./obj_dir/sim_icache_subsys 2>&1) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1
